// File: Bender.yml
package:
  name: quad_bram_ctrl

sources:
  - common/quad_ctrl_pkg.sv
  - hdl/job_fsm.sv
  - hdl/window_timer.sv
  - pfb_reader/pfb_reader.sv
  - pix_seq_reader/pix_seq_reader.sv
  - hdl/quad_bram_ctrl.sv
  - target: test
    files:
      - bench/tb_quad_bram_ctrl.sv

// File: bench/tb_quad_bram_ctrl.sv
`timescale 1ns/1ps

module tb_quad_bram_ctrl;
    import quad_ctrl_pkg::*;

    localparam int NUM_JOBS = 3;

    logic          clk;
    logic          rst;
    logic          job_start;
    logic          job_accept;
    logic          job_fetch_request;
    logic          job_fetch_ack;
    logic          job_fetch_complete;
    logic          job_complete;
    logic          job_complete_ack;
    logic          pipeline_flushed;
    buf_idx_t      num_expd_input_cols;
    buf_idx_t      num_expd_input_rows;
    kernel_idx_t   num_kernels;
    pfb_cnt_t      pfb_full_count;
    pix_seq_addr_t pix_seq_data_full_count;
    ctrl_state_t   state;
    gray_t         gray_code;
    buf_idx_t      input_row;
    buf_idx_t      input_col;
    logic          next_row;
    logic          pfb_rden;
    logic          pix_seq_bram_rden;
    pix_seq_addr_t pix_seq_bram_rd_addr;
    ce_vec_t       ce_execute;
    window_cyc_t   cycle_counter;
    logic          ctrl_last_kernel;

    // Reference state kept from the host side
    int            fail_cnt;
    int            job_idx;
    int            cycles;
    int            cycle_limit;
    int            model_words;
    int            rd_since_load;
    int            exp_col;
    logic          exp_wrap;
    int            row_pulses;
    int            win_idx;
    pix_seq_addr_t exp_addr;
    logic [1:0]    passes;
    logic          last_prev;
    logic          last_fell;
    int            job_rows [NUM_JOBS];
    int            job_cols [NUM_JOBS];
    int            job_kern [NUM_JOBS];
    int            job_seq [NUM_JOBS];

    quad_bram_ctrl i_quad_bram_ctrl (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int job_cycle_budget(int r, int c, int k, int s);
        int reads;
        reads = (r + 2) * (c + 1);
        return 2 * (reads * (k + 1) * (s + 15) + (r + 2) * 40 + 200);
    endfunction

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
    endtask

    ////////////////////
    // Reference models
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            model_words   <= 0;
            rd_since_load <= 0;
            exp_col       <= 0;
            exp_wrap      <= 1'b0;
            row_pulses    <= 0;
            win_idx       <= 0;
            exp_addr      <= '0;
            passes        <= 2'd0;
            last_prev     <= 1'b0;
            last_fell     <= 1'b0;
        end else begin
            if (job_fetch_complete) begin
                model_words   <= pfb_full_count;
                rd_since_load <= 0;
            end else if (pfb_rden) begin
                model_words   <= model_words - 1;
                rd_since_load <= rd_since_load + 1;
            end
            // Column wraps after the read at num_expd_input_cols
            exp_wrap <= pfb_rden && exp_col == num_expd_input_cols;
            if (job_complete && job_complete_ack) begin
                exp_col <= 0;
            end else if (pfb_rden) begin
                exp_col <= (exp_col == num_expd_input_cols) ? 0 : exp_col + 1;
            end
            exp_addr  <= pix_seq_bram_rden ? exp_addr + 1'b1 : '0;
            last_prev <= ce_execute[NUM_CE-1];
            last_fell <= ce_execute[NUM_CE-1] === 1'b0 && last_prev === 1'b1;
            if (job_complete && job_complete_ack) begin
                passes        <= 2'd0;
                rd_since_load <= 0;
            end else if (last_fell) begin
                passes <= passes + 2'd1;
            end
            if (job_accept) begin
                row_pulses <= 0;
                win_idx    <= 0;
            end else begin
                if (next_row) begin
                    row_pulses <= row_pulses + 1;
                end
                if (pix_seq_bram_rden && (exp_addr % WINDOW_CYCLES) == WINDOW_CYCLES - 1) begin
                    win_idx <= win_idx + 1;
                end
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_reset_values: assert property (@(posedge clk) $fell(rst) |->
        {job_accept, job_fetch_request, job_complete, pfb_rden, pix_seq_bram_rden,
         ce_execute, next_row, gray_code} == '0 && state == ST_IDLE)
        else begin
            fail_cnt++;
            $display("Outputs were not cleared by reset");
        end

    a_accept_cause: assert property (@(posedge clk) disable iff (rst)
        job_accept |-> $past(state) == ST_IDLE && $past(job_start))
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d accept: expected 0 actual 1", job_idx);
        end

    a_accept_given: assert property (@(posedge clk) disable iff (rst)
        $past(state) == ST_IDLE && $past(job_start) && !$past(rst) |-> job_accept)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d accept: expected 1 actual 0", job_idx);
        end

    a_accept_pulse: assert property (@(posedge clk) disable iff (rst)
        job_accept |=> !job_accept)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d accept_width: expected 0 actual 1", job_idx);
        end

    a_request_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(job_fetch_request) |-> $past(model_words) == 0)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d request_rise: expected words 0 actual %0d",
                     job_idx, $past(model_words));
        end

    a_request_fall: assert property (@(posedge clk) disable iff (rst)
        job_fetch_request && job_fetch_ack |=> !job_fetch_request)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d request_fall: expected 0 actual 1", job_idx);
        end

    a_request_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(job_fetch_request) |-> $past(job_fetch_ack))
        else begin
            fail_cnt++;
            $display("Fetch request dropped without an acknowledge in job%0d", job_idx);
        end

    a_pfb_reads: assert property (@(posedge clk) disable iff (rst)
        rd_since_load <= pfb_full_count)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d pfb_reads: expected <= %0d actual %0d",
                     job_idx, pfb_full_count, rd_since_load);
        end

    a_col_range: assert property (@(posedge clk) disable iff (rst)
        input_col <= num_expd_input_cols)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d input_col: expected <= %0d actual %0d",
                     job_idx, num_expd_input_cols, input_col);
        end

    a_next_row: assert property (@(posedge clk) disable iff (rst)
        next_row == exp_wrap)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d next_row: expected %0b actual %0b", job_idx,
                     exp_wrap, next_row);
        end

    a_row_total: assert property (@(posedge clk) disable iff (rst)
        $rose(job_complete) |-> row_pulses == num_expd_input_rows + 1)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d row_total: expected %0d actual %0d",
                     job_idx, num_expd_input_rows + 1, row_pulses);
        end

    a_rd_addr: assert property (@(posedge clk) disable iff (rst)
        pix_seq_bram_rden |-> pix_seq_bram_rd_addr == exp_addr)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d rd_addr: expected %0d actual %0d",
                     job_idx, exp_addr, pix_seq_bram_rd_addr);
        end

    a_rd_count: assert property (@(posedge clk) disable iff (rst)
        $fell(pix_seq_bram_rden) |-> exp_addr == pix_seq_data_full_count)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d rd_count: expected %0d actual %0d",
                     job_idx, pix_seq_data_full_count, exp_addr);
        end

    a_exec_head: assert property (@(posedge clk) disable iff (rst)
        ce_execute[0] == $past(pix_seq_bram_rden, PIX_SEQ_RD_LATENCY))
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d exec_head: expected %0b actual %0b", job_idx,
                     $past(pix_seq_bram_rden, PIX_SEQ_RD_LATENCY), ce_execute[0]);
        end

    a_exec_chain: assert property (@(posedge clk) disable iff (rst)
        ce_execute[NUM_CE-1:1] == $past(ce_execute[NUM_CE-2:0]))
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d exec_chain: expected %h actual %h", job_idx,
                     $past(ce_execute[NUM_CE-2:0]), ce_execute[NUM_CE-1:1]);
        end

    a_window_cycle: assert property (@(posedge clk) disable iff (rst)
        pix_seq_bram_rden |-> cycle_counter == exp_addr % WINDOW_CYCLES)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d cycle_counter: expected %0d actual %0d",
                     job_idx, exp_addr % WINDOW_CYCLES, cycle_counter);
        end

    a_last_kernel: assert property (@(posedge clk) disable iff (rst)
        pix_seq_bram_rden |-> ctrl_last_kernel == (win_idx % (num_kernels + 1) == num_kernels))
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d last_kernel: expected %0b actual %0b", job_idx,
                     win_idx % (num_kernels + 1) == num_kernels, ctrl_last_kernel);
        end

    a_gray: assert property (@(posedge clk) disable iff (rst)
        gray_code == (passes ^ (passes >> 1)))
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d gray_code: expected %b actual %b", job_idx,
                     passes ^ (passes >> 1), gray_code);
        end

    a_complete_hold: assert property (@(posedge clk) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else begin
            fail_cnt++;
            $display("[FAIL] job%0d complete_hold: expected 1 actual 0", job_idx);
        end

    a_complete_end: assert property (@(posedge clk) disable iff (rst)
        job_complete && job_complete_ack |=>
        !job_complete && state == ST_IDLE && input_row == '0 && input_col == '0)
        else begin
            fail_cnt++;
            $display("Job%0d did not return to idle with cleared counters", job_idx);
        end

    ////////////////////
    // Host models
    ////////////////////

    initial begin
        forever begin
            @(posedge clk);
            if (job_fetch_request && !job_fetch_ack) begin
                wait_cycles($urandom_range(7, 0));
                job_fetch_ack <= 1'b1;
                @(posedge clk);
                job_fetch_ack <= 1'b0;
                wait_cycles($urandom_range(8, 1));
                job_fetch_complete <= 1'b1;
                @(posedge clk);
                job_fetch_complete <= 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (state == ST_WAIT_JOB_DONE && !pipeline_flushed) begin
                wait_cycles($urandom_range(6, 1));
                pipeline_flushed <= 1'b1;
                @(posedge clk);
                pipeline_flushed <= 1'b0;
            end else if (job_complete && !job_complete_ack) begin
                wait_cycles($urandom_range(6, 1));
                job_complete_ack <= 1'b1;
                @(posedge clk);
                job_complete_ack <= 1'b0;
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles in job%0d", cycles, job_idx);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic run_job(int n);
        int errs_before;
        errs_before = fail_cnt;
        @(posedge clk);
        num_expd_input_rows     <= buf_idx_t'(job_rows[n]);
        num_expd_input_cols     <= buf_idx_t'(job_cols[n]);
        num_kernels             <= kernel_idx_t'(job_kern[n]);
        pfb_full_count          <= pfb_cnt_t'(job_cols[n] + 1);
        pix_seq_data_full_count <= pix_seq_addr_t'(job_seq[n]);
        @(posedge clk);
        job_start <= 1'b1;
        do @(posedge clk); while (!job_accept);
        job_start <= 1'b0;
        while (!(job_complete && job_complete_ack)) @(posedge clk);
        wait_cycles(3);
        $display("job%0d rows %0d cols %0d kernels %0d seq %0d: %s", n, job_rows[n],
                 job_cols[n], job_kern[n], job_seq[n],
                 (fail_cnt == errs_before) ? "ok" : "errors");
    endtask

    initial begin
        int seed_dummy;
        int failed_jobs;
        int errs_before;
        seed_dummy = $urandom(32'hbeff3377);
        fail_cnt = 0;
        failed_jobs = 0;
        job_idx = 0;
        cycles = 0;
        cycle_limit = 0;
        rst = 1'b1;
        job_start = 1'b0;
        job_fetch_ack = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack = 1'b0;
        pipeline_flushed = 1'b0;
        num_expd_input_cols = '0;
        num_expd_input_rows = '0;
        num_kernels = '0;
        pfb_full_count = '0;
        pix_seq_data_full_count = '0;
        for (int i = 0; i < NUM_JOBS; i++) begin
            job_rows[i] = $urandom_range(6, 4);
            job_cols[i] = $urandom_range(5, 3);
            job_kern[i] = $urandom_range(3, 1);
            job_seq[i]  = 9 * $urandom_range(2, 1);
            cycle_limit += job_cycle_budget(job_rows[i], job_cols[i], job_kern[i], job_seq[i]);
        end
        wait_cycles(8);
        rst <= 1'b0;
        for (int i = 0; i < NUM_JOBS; i++) begin
            job_idx = i;
            errs_before = fail_cnt;
            run_job(i);
            if (fail_cnt != errs_before) begin
                failed_jobs++;
            end
        end
        $display("Tests: %0d run, %0d passed, %0d failed, %0d check errors", NUM_JOBS,
                 NUM_JOBS - failed_jobs, failed_jobs, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: common/quad_ctrl_pkg.sv
package quad_ctrl_pkg;

    ////////////////////
    // Buffer geometry
    ////////////////////

    localparam int ROW_BUF_BRAM_DEPTH = 1024;
    localparam int BUF_IDX_W = $clog2(ROW_BUF_BRAM_DEPTH);
    localparam int PFB_CNT_W = 10;
    localparam int PIX_SEQ_ADDR_W = 12;

    // Kernel groups held in the row-buffer BRAM
    localparam int MAX_BRAM_3X3_KERNELS = 16;
    localparam int KERNEL_IDX_W = $clog2(MAX_BRAM_3X3_KERNELS);

    // One 3x3 window is nine pixel-sequence reads
    localparam int WINDOW_CYCLES = 9;
    localparam int WINDOW_CYC_W = $clog2(WINDOW_CYCLES);

    ////////////////////
    // Compute engines
    ////////////////////

    localparam int NUM_AWE = 4;
    localparam int NUM_CE_PER_AWE = 2;
    localparam int NUM_CE = NUM_AWE * NUM_CE_PER_AWE;

    localparam int PIX_SEQ_RD_LATENCY = 3;
    // Rows read in before the first pass
    localparam int PRIME_ROWS = 3;

    typedef logic [BUF_IDX_W-1:0]      buf_idx_t;
    typedef logic [PFB_CNT_W-1:0]      pfb_cnt_t;
    typedef logic [PIX_SEQ_ADDR_W-1:0] pix_seq_addr_t;
    typedef logic [KERNEL_IDX_W-1:0]   kernel_idx_t;
    typedef logic [WINDOW_CYC_W-1:0]   window_cyc_t;
    typedef logic [NUM_CE-1:0]         ce_vec_t;
    typedef logic [1:0]                gray_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRIME_BUFFER,
        ST_WAIT_PFB_LOAD,
        ST_CE_ACTIVE,
        ST_WAIT_JOB_DONE,
        ST_SEND_COMPLETE
    } ctrl_state_t;

endpackage

// File: hdl/job_fsm.sv
`timescale 1ns/1ps

module job_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       job_start,
    input  logic                       job_fetch_ack,
    input  logic                       job_fetch_complete,
    input  logic                       job_complete_ack,
    input  logic                       pipeline_flushed,
    input  logic                       pfb_empty,
    input  logic                       prime_done,
    input  logic                       rows_done,
    input  logic                       pass_done,
    output logic                       job_accept,
    output logic                       job_fetch_request,
    output logic                       job_complete,
    output quad_ctrl_pkg::ctrl_state_t state,
    output quad_ctrl_pkg::gray_t       gray_code,
    output logic                       prime_en,
    output logic                       pfb_load,
    output logic                       job_clear,
    output logic                       pass_start
);
    import quad_ctrl_pkg::*;

    ctrl_state_t return_state;
    logic        fetch_in_progress;
    logic        fetch_acked;
    logic [1:0]  pass_cnt;

    assign prime_en  = (state == ST_PRIME_BUFFER);
    assign pfb_load  = job_fetch_complete && fetch_in_progress;
    assign job_clear = (state == ST_SEND_COMPLETE) && job_complete && job_complete_ack;
    // Row-buffer roles rotate once per finished pass
    assign gray_code = {pass_cnt[1], ^pass_cnt};

    ////////////////////
    // Host fetch tracking
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_in_progress <= 1'b0;
        end else if (job_fetch_complete) begin
            fetch_in_progress <= 1'b0;
        end else if (job_fetch_ack && job_fetch_request) begin
            fetch_in_progress <= 1'b1;
        end
    end

    ////////////////////
    // Job sequencing
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= ST_IDLE;
            return_state      <= ST_IDLE;
            fetch_acked       <= 1'b0;
            pass_cnt          <= 2'd0;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            pass_start        <= 1'b0;
        end else begin
            job_accept <= 1'b0;
            pass_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= ST_PRIME_BUFFER;
                    end
                end
                ST_PRIME_BUFFER: begin
                    // Primed once the row after the window is sitting in the pfb
                    if (prime_done) begin
                        pass_start <= 1'b1;
                        state      <= ST_CE_ACTIVE;
                    end else if (pfb_empty) begin
                        return_state <= ST_PRIME_BUFFER;
                        state        <= ST_WAIT_PFB_LOAD;
                    end
                end
                ST_WAIT_PFB_LOAD: begin
                    if (job_fetch_request && job_fetch_ack) begin
                        job_fetch_request <= 1'b0;
                        fetch_acked       <= 1'b1;
                    end else if (pfb_empty && !fetch_acked && !fetch_in_progress) begin
                        job_fetch_request <= 1'b1;
                    end
                    if (pfb_load) begin
                        fetch_acked <= 1'b0;
                        pass_start  <= (return_state == ST_CE_ACTIVE);
                        state       <= return_state;
                    end
                end
                ST_CE_ACTIVE: begin
                    if (pass_done) begin
                        pass_cnt <= pass_cnt + 2'd1;
                        if (rows_done) begin
                            state <= ST_WAIT_JOB_DONE;
                        end else if (pfb_empty) begin
                            return_state <= ST_CE_ACTIVE;
                            state        <= ST_WAIT_PFB_LOAD;
                        end else begin
                            pass_start <= 1'b1;
                        end
                    end
                end
                ST_WAIT_JOB_DONE: begin
                    if (pipeline_flushed) begin
                        state <= ST_SEND_COMPLETE;
                    end
                end
                ST_SEND_COMPLETE: begin
                    // Held until the host acknowledges
                    job_complete <= !job_clear;
                    if (job_clear) begin
                        pass_cnt <= 2'd0;
                        state    <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    a_no_request_in_fetch: assert property (@(posedge clk) disable iff (rst)
        !(job_fetch_request && fetch_in_progress));

    a_accept_from_idle: assert property (@(posedge clk) disable iff (rst)
        job_accept |-> $past(state) == ST_IDLE);

endmodule

// File: hdl/quad_bram_ctrl.sv
`timescale 1ns/1ps

module quad_bram_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        job_start,
    output logic                        job_accept,
    output logic                        job_fetch_request,
    input  logic                        job_fetch_ack,
    input  logic                        job_fetch_complete,
    output logic                        job_complete,
    input  logic                        job_complete_ack,
    input  logic                        pipeline_flushed,
    input  quad_ctrl_pkg::buf_idx_t     num_expd_input_cols,
    input  quad_ctrl_pkg::buf_idx_t     num_expd_input_rows,
    input  quad_ctrl_pkg::kernel_idx_t  num_kernels,
    input  quad_ctrl_pkg::pfb_cnt_t     pfb_full_count,
    input  quad_ctrl_pkg::pix_seq_addr_t pix_seq_data_full_count,
    output quad_ctrl_pkg::ctrl_state_t  state,
    output quad_ctrl_pkg::gray_t        gray_code,
    output quad_ctrl_pkg::buf_idx_t     input_row,
    output quad_ctrl_pkg::buf_idx_t     input_col,
    output logic                        next_row,
    output logic                        pfb_rden,
    output logic                        pix_seq_bram_rden,
    output quad_ctrl_pkg::pix_seq_addr_t pix_seq_bram_rd_addr,
    output quad_ctrl_pkg::ce_vec_t      ce_execute,
    output quad_ctrl_pkg::window_cyc_t  cycle_counter,
    output logic                        ctrl_last_kernel
);
    import quad_ctrl_pkg::*;

    // Sequencing strobes from the job FSM
    logic prime_en;
    logic pfb_load;
    logic job_clear;
    logic pass_start;

    // Status back to the job FSM
    logic pfb_empty;
    logic prime_done;
    logic rows_done;
    logic pass_done;
    logic kernel_wrap;

    job_fsm i_job_fsm (
        .clk                (clk),
        .rst                (rst),
        .job_start          (job_start),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete_ack   (job_complete_ack),
        .pipeline_flushed   (pipeline_flushed),
        .pfb_empty          (pfb_empty),
        .prime_done         (prime_done),
        .rows_done          (rows_done),
        .pass_done          (pass_done),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_complete       (job_complete),
        .state              (state),
        .gray_code          (gray_code),
        .prime_en           (prime_en),
        .pfb_load           (pfb_load),
        .job_clear          (job_clear),
        .pass_start         (pass_start)
    );

    window_timer i_window_timer (
        .clk              (clk),
        .rst              (rst),
        .pix_seq_rden     (pix_seq_bram_rden),
        .num_kernels      (num_kernels),
        .job_clear        (job_clear),
        .cycle_counter    (cycle_counter),
        .ctrl_last_kernel (ctrl_last_kernel),
        .window_end       (),
        .kernel_wrap      (kernel_wrap)
    );

    pfb_reader i_pfb_reader (
        .clk                 (clk),
        .rst                 (rst),
        .pfb_full_count      (pfb_full_count),
        .num_expd_input_cols (num_expd_input_cols),
        .num_expd_input_rows (num_expd_input_rows),
        .pfb_load            (pfb_load),
        .job_clear           (job_clear),
        .prime_en            (prime_en),
        .kernel_wrap         (kernel_wrap),
        .pfb_rden            (pfb_rden),
        .next_row            (next_row),
        .input_row           (input_row),
        .input_col           (input_col),
        .pfb_empty           (pfb_empty),
        .prime_done          (prime_done),
        .rows_done           (rows_done)
    );

    pix_seq_reader i_pix_seq_reader (
        .clk                     (clk),
        .rst                     (rst),
        .pass_start              (pass_start),
        .pix_seq_data_full_count (pix_seq_data_full_count),
        .pix_seq_bram_rden       (pix_seq_bram_rden),
        .pix_seq_bram_rd_addr    (pix_seq_bram_rd_addr),
        .ce_execute              (ce_execute),
        .pass_done               (pass_done)
    );

endmodule

// File: hdl/window_timer.sv
`timescale 1ns/1ps

module window_timer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pix_seq_rden,
    input  quad_ctrl_pkg::kernel_idx_t num_kernels,
    input  logic                       job_clear,
    output quad_ctrl_pkg::window_cyc_t cycle_counter,
    output logic                       ctrl_last_kernel,
    output logic                       window_end,
    output logic                       kernel_wrap
);
    import quad_ctrl_pkg::*;

    kernel_idx_t kernel_group;

    // Last read of a 3x3 window
    assign window_end       = pix_seq_rden && (cycle_counter == window_cyc_t'(WINDOW_CYCLES - 1));
    assign ctrl_last_kernel = (kernel_group == num_kernels);
    assign kernel_wrap      = window_end && ctrl_last_kernel;

    ////////////////////
    // Window cycle
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst || job_clear) begin
            cycle_counter <= '0;
        end else if (window_end) begin
            cycle_counter <= '0;
        end else if (pix_seq_rden) begin
            cycle_counter <= cycle_counter + 1'b1;
        end
    end

    // Kernel group, 0 up to num_kernels inclusive
    always_ff @(posedge clk) begin
        if (rst || job_clear) begin
            kernel_group <= '0;
        end else if (kernel_wrap) begin
            kernel_group <= '0;
        end else if (window_end) begin
            kernel_group <= kernel_group + 1'b1;
        end
    end

    a_cycle_in_window: assert property (@(posedge clk) disable iff (rst)
        cycle_counter < window_cyc_t'(WINDOW_CYCLES));

endmodule

// File: pfb_reader/pfb_reader.sv
`timescale 1ns/1ps

module pfb_reader (
    input  logic                    clk,
    input  logic                    rst,
    input  quad_ctrl_pkg::pfb_cnt_t pfb_full_count,
    input  quad_ctrl_pkg::buf_idx_t num_expd_input_cols,
    input  quad_ctrl_pkg::buf_idx_t num_expd_input_rows,
    input  logic                    pfb_load,
    input  logic                    job_clear,
    input  logic                    prime_en,
    input  logic                    kernel_wrap,
    output logic                    pfb_rden,
    output logic                    next_row,
    output quad_ctrl_pkg::buf_idx_t input_row,
    output quad_ctrl_pkg::buf_idx_t input_col,
    output logic                    pfb_empty,
    output logic                    prime_done,
    output logic                    rows_done
);
    import quad_ctrl_pkg::*;

    pfb_cnt_t pfb_count;
    logic     row_wrap;
    logic     rd_avail;
    logic     prime_rd;
    logic     rd_req;

    assign pfb_empty  = (pfb_count == '0);
    assign prime_done = (input_row == buf_idx_t'(PRIME_ROWS)) && (pfb_count == pfb_full_count);
    assign rows_done  = (input_row > num_expd_input_rows);

    // Read in flight that finishes the current row
    assign row_wrap = pfb_rden && (input_col == num_expd_input_cols);
    // Words left once the read in flight lands
    assign rd_avail = pfb_rden ? (pfb_count > pfb_cnt_t'(1)) : !pfb_empty;
    assign prime_rd = prime_en && (input_row < buf_idx_t'(PRIME_ROWS))
                    && !(row_wrap && input_row == buf_idx_t'(PRIME_ROWS - 1));
    assign rd_req   = prime_en ? prime_rd : kernel_wrap;

    always_ff @(posedge clk) begin
        if (rst || job_clear) begin
            pfb_rden <= 1'b0;
        end else begin
            pfb_rden <= rd_req && rd_avail;
        end
    end

    ////////////////////
    // Word count
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst || job_clear) begin
            pfb_count <= '0;
        end else if (pfb_load) begin
            pfb_count <= pfb_full_count;
        end else if (pfb_rden) begin
            pfb_count <= pfb_count - 1'b1;
        end
    end

    // Input position follows each word read
    always_ff @(posedge clk) begin
        if (rst || job_clear) begin
            input_row <= '0;
            input_col <= '0;
            next_row  <= 1'b0;
        end else begin
            next_row <= row_wrap;
            if (row_wrap) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else if (pfb_rden) begin
                input_col <= input_col + 1'b1;
            end
        end
    end

    a_no_read_when_empty: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> !pfb_empty);

endmodule

// File: pix_seq_reader/pix_seq_reader.sv
`timescale 1ns/1ps

module pix_seq_reader (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pass_start,
    input  quad_ctrl_pkg::pix_seq_addr_t pix_seq_data_full_count,
    output logic                         pix_seq_bram_rden,
    output quad_ctrl_pkg::pix_seq_addr_t pix_seq_bram_rd_addr,
    output quad_ctrl_pkg::ce_vec_t       ce_execute,
    output logic                         pass_done
);
    import quad_ctrl_pkg::*;

    pix_seq_addr_t                 rd_remaining;
    logic [PIX_SEQ_RD_LATENCY-1:0] rd_dly;
    logic [NUM_CE-2:0]             exec_tail;
    logic                          exec_last_d;
    logic                          exec_fall;

    ////////////////////
    // Sequence reads
    ////////////////////

    // Reads back to back from address 0 for the whole pass
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_seq_bram_rden    <= 1'b0;
            pix_seq_bram_rd_addr <= '0;
            rd_remaining         <= '0;
        end else if (pass_start) begin
            pix_seq_bram_rden    <= (pix_seq_data_full_count != '0);
            pix_seq_bram_rd_addr <= '0;
            rd_remaining         <= pix_seq_data_full_count;
        end else if (pix_seq_bram_rden) begin
            rd_remaining      <= rd_remaining - 1'b1;
            pix_seq_bram_rden <= (rd_remaining > pix_seq_addr_t'(1));
            if (rd_remaining > pix_seq_addr_t'(1)) begin
                pix_seq_bram_rd_addr <= pix_seq_bram_rd_addr + 1'b1;
            end
        end
    end

    ////////////////////
    // CE execute chain
    ////////////////////

    // First CE starts when BRAM data is valid, the rest follow one cycle apart
    assign ce_execute = {exec_tail, rd_dly[PIX_SEQ_RD_LATENCY-1]};
    assign exec_fall  = exec_last_d && !ce_execute[NUM_CE-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_dly      <= '0;
            exec_tail   <= '0;
            exec_last_d <= 1'b0;
            pass_done   <= 1'b0;
        end else begin
            rd_dly      <= {rd_dly[PIX_SEQ_RD_LATENCY-2:0], pix_seq_bram_rden};
            exec_tail   <= ce_execute[NUM_CE-2:0];
            exec_last_d <= ce_execute[NUM_CE-1];
            // Last CE done and nothing left to read
            pass_done   <= exec_fall && (rd_remaining == '0);
        end
    end

    a_addr_in_range: assert property (@(posedge clk) disable iff (rst)
        pix_seq_bram_rden |-> pix_seq_bram_rd_addr < pix_seq_data_full_count);

endmodule

// File: quad_bram_ctrl.f
common/quad_ctrl_pkg.sv
hdl/job_fsm.sv
hdl/window_timer.sv
pfb_reader/pfb_reader.sv
pix_seq_reader/pix_seq_reader.sv
hdl/quad_bram_ctrl.sv
bench/tb_quad_bram_ctrl.sv
